// ==== hw/stream_pkg.sv ====
package stream_pkg;

    // stream word geometry
    localparam int WORD_WIDTH = 32;
    localparam int KEEP_WIDTH = 4;

    // width of the request and acceptance counters
    // sized for a full frame of words
    localparam int REQ_CNT_WIDTH = 24;

    // one stream beat
    typedef logic [WORD_WIDTH-1:0] word_t;

    // byte qualifiers of a beat
    typedef logic [KEEP_WIDTH-1:0] keep_t;

    // capture controller states
    typedef enum logic [2:0] {
        // one cycle after reset
        CAP_IDLE,
        // buffer flushed, looking for vsync rise with tvalid
        CAP_WAIT_FRAME,
        // frame open, first de not seen yet
        CAP_WAIT_LINE,
        // counting de requests against accepted words
        CAP_STREAM,
        // vsync fell, back to waiting next cycle
        CAP_FRAME_END
    } capture_state_t;

endpackage

// ==== hw/video_pkg.sv ====
package video_pkg;

    // sync delay in clock cycles
    // output register adds one more
    localparam int LINE_PERIOD = 16;

    // line buffer geometry
    localparam int BUF_ADDR_WIDTH = 12;
    localparam int BUF_DEPTH = 1 << BUF_ADDR_WIDTH;

    // one output byte lane
    localparam int PIXEL_WIDTH = 8;

    // sync group as carried through the delay line
    // de in the top bit, vsync in the bottom bit
    typedef struct packed {
        logic de;
        logic valid;
        logic hsync;
        logic vsync;
    } sync_t;

endpackage

// ==== hw/line_buf_if.sv ====
interface line_buf_if
    import stream_pkg::*;
();

    // write side
    logic  push;
    word_t push_data;
    logic  flush;
    logic  full;

    // read side
    logic  pop;
    word_t pop_data;
    logic  empty;

    // capture writes accepted words and flushes between frames
    modport capture (
        output push,
        output push_data,
        output flush,
        input  full
    );

    // the store itself
    modport store (
        input  push,
        input  push_data,
        input  flush,
        input  pop,
        output full,
        output empty,
        output pop_data
    );

    // replay takes one word per delayed de cycle
    modport replay (
        output pop,
        input  pop_data,
        input  empty
    );

endinterface

// ==== hw/stream_capture.sv ====
module stream_capture
    import stream_pkg::*;
(
    input  logic        out_clk,
    input  logic        rstn,
    input  logic        in_tvalid,
    input  word_t       in_tdata,
    input  keep_t       in_tkeep,
    input  logic        in_de,
    input  logic        in_vs,
    output logic        out_tready,
    line_buf_if.capture lbuf
);

    capture_state_t state;

    // previous samples for edge detect
    logic de_q;
    logic vs_q;

    logic de_rise;
    logic vs_rise;
    logic vs_fall;

    // open requests vs words taken
    logic [REQ_CNT_WIDTH-1:0] req_cnt;
    logic [REQ_CNT_WIDTH-1:0] acc_cnt;
    logic [REQ_CNT_WIDTH-1:0] req_next;
    logic [REQ_CNT_WIDTH-1:0] acc_next;

    logic  all_keep;
    logic  accept;
    logic  flush_q;
    logic  push_q;
    word_t word_q;

    assign de_rise = in_de & ~de_q;
    assign vs_rise = in_vs & ~vs_q;
    assign vs_fall = ~in_vs & vs_q;

    // partial words are never taken
    assign all_keep = &in_tkeep;
    assign accept   = out_tready & in_tvalid & all_keep;

    // counts after this cycle
    always_comb
    begin
        req_next = req_cnt;
        acc_next = acc_cnt + REQ_CNT_WIDTH'(accept);
        case (state)
            // first de of the frame opens the first request
            CAP_WAIT_LINE:
                if (de_rise)
                    req_next = req_cnt + 1'b1;
            // every de cycle is one more pixel owed
            CAP_STREAM:
                if (in_de)
                    req_next = req_cnt + 1'b1;
            default:
                req_next = req_cnt;
        endcase
    end

    always_ff @(posedge out_clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state      <= CAP_IDLE;
            de_q       <= 1'b0;
            vs_q       <= 1'b0;
            req_cnt    <= '0;
            acc_cnt    <= '0;
            out_tready <= 1'b0;
            flush_q    <= 1'b0;
            push_q     <= 1'b0;
        end
        else
        begin
            de_q   <= in_de;
            vs_q   <= in_vs;
            // accepted word lands in the buffer next cycle
            push_q <= accept;
            case (state)
                CAP_IDLE:
                begin
                    out_tready <= 1'b0;
                    flush_q    <= 1'b1;
                    state      <= CAP_WAIT_FRAME;
                end
                CAP_WAIT_FRAME:
                begin
                    out_tready <= 1'b0;
                    // frame only starts if the stream is already offering
                    if (vs_rise && in_tvalid)
                    begin
                        req_cnt <= '0;
                        acc_cnt <= '0;
                        flush_q <= 1'b0;
                        state   <= CAP_WAIT_LINE;
                    end
                end
                CAP_WAIT_LINE:
                begin
                    req_cnt    <= req_next;
                    out_tready <= (req_next != acc_next);
                    if (vs_fall)
                    begin
                        out_tready <= 1'b0;
                        state      <= CAP_FRAME_END;
                    end
                    else if (de_rise)
                        state <= CAP_STREAM;
                end
                CAP_STREAM:
                begin
                    req_cnt <= req_next;
                    acc_cnt <= acc_next;
                    // drops right after the last open request is met
                    out_tready <= (req_next != acc_next);
                    if (vs_fall)
                    begin
                        out_tready <= 1'b0;
                        state      <= CAP_FRAME_END;
                    end
                end
                CAP_FRAME_END:
                begin
                    out_tready <= 1'b0;
                    flush_q    <= 1'b1;
                    state      <= CAP_WAIT_FRAME;
                end
                default:
                begin
                    out_tready <= 1'b0;
                    state      <= CAP_IDLE;
                end
            endcase
        end
    end

    // payload only
    always_ff @(posedge out_clk)
    begin
        if (accept)
            word_q <= in_tdata;
    end

    assign lbuf.push      = push_q;
    assign lbuf.push_data = word_q;
    assign lbuf.flush     = flush_q;

    // no handshake while waiting for a frame
    a_no_tready_wait: assert property (@(posedge out_clk) disable iff (!rstn)
        (state == CAP_WAIT_FRAME) |-> !out_tready);

    // buffer must have room for every accepted word
    a_no_push_full: assert property (@(posedge out_clk) disable iff (!rstn)
        lbuf.push |-> !lbuf.full);

    // flush would drop a word pushed in the same cycle
    a_no_flush_push: assert property (@(posedge out_clk) disable iff (!rstn)
        !(lbuf.flush && lbuf.push));

endmodule

// ==== hw/line_buffer.sv ====
module line_buffer
    import stream_pkg::*, video_pkg::*;
(
    input  logic      out_clk,
    input  logic      rstn,
    line_buf_if.store lbuf
);

    word_t mem [BUF_DEPTH];

    logic [BUF_ADDR_WIDTH-1:0] wr_ptr;
    logic [BUF_ADDR_WIDTH-1:0] rd_ptr;
    // one bit wider than the pointers
    logic [BUF_ADDR_WIDTH:0]   count;

    // storage array
    always_ff @(posedge out_clk)
    begin
        if (lbuf.push)
            mem[wr_ptr] <= lbuf.push_data;
    end

    // pointers and occupancy
    always_ff @(posedge out_clk or negedge rstn)
    begin
        if (!rstn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (lbuf.flush)
        begin
            // drop whatever is left from the last frame
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            // pointers wrap at the depth
            if (lbuf.push)
                wr_ptr <= wr_ptr + 1'b1;
            if (lbuf.pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({lbuf.push, lbuf.pop})
                2'b10:
                    count <= count + 1'b1;
                2'b01:
                    count <= count - 1'b1;
                default:
                    count <= count;
            endcase
        end
    end

    // head word shown without a read cycle
    assign lbuf.pop_data = mem[rd_ptr];

    // msb alone means exactly BUF_DEPTH words held
    assign lbuf.full  = count[BUF_ADDR_WIDTH];
    assign lbuf.empty = (count == '0);

    // catches both overflow and a wrapped underflow
    a_count_range: assert property (@(posedge out_clk) disable iff (!rstn)
        count <= BUF_DEPTH);

endmodule

// ==== hw/sync_replay.sv ====
module sync_replay
    import stream_pkg::*, video_pkg::*;
(
    input  logic       out_clk,
    input  logic       rstn,
    input  sync_t      sync_in,
    output sync_t      sync_out,
    output word_t      pixel_word,
    line_buf_if.replay lbuf
);

    // one line period of sync history
    sync_t dly [LINE_PERIOD];

    logic de_late;

    // oldest stage drives the buffer read
    assign de_late  = dly[LINE_PERIOD-1].de;
    assign lbuf.pop = de_late;

    always_ff @(posedge out_clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < LINE_PERIOD; i++)
                dly[i] <= '0;
            sync_out <= '0;
        end
        else
        begin
            dly[0] <= sync_in;
            for (int i = 1; i < LINE_PERIOD; i++)
                dly[i] <= dly[i-1];
            // final register
            // total latency is LINE_PERIOD + 1
            sync_out <= dly[LINE_PERIOD-1];
        end
    end

    // word registered on the same edge as out_de
    // so bytes and de move together
    always_ff @(posedge out_clk)
    begin
        if (de_late)
            pixel_word <= lbuf.pop_data;
    end

    // capture must have supplied each pixel before its delayed de
    a_no_pop_empty: assert property (@(posedge out_clk) disable iff (!rstn)
        lbuf.pop |-> !lbuf.empty);

endmodule

// ==== hw/axi_stream_video_out.sv ====
module axi_stream_video_out
    import stream_pkg::*, video_pkg::*;
(
    input  logic                   out_clk,
    input  logic                   rstn,

    // video stream in
    input  logic                   in_tvalid,
    input  word_t                  in_tdata,
    input  keep_t                  in_tkeep,
    output logic                   out_tready,

    // incoming video timing
    input  logic                   in_valid,
    input  logic                   in_de,
    input  logic                   in_hs,
    input  logic                   in_vs,

    // delayed raster out
    output logic                   out_de,
    output logic                   out_valid,
    output logic                   out_hsync,
    output logic                   out_vsync,
    output logic [PIXEL_WIDTH-1:0] out_rd_00,
    output logic [PIXEL_WIDTH-1:0] out_rd_01,
    output logic [PIXEL_WIDTH-1:0] out_rd_10,
    output logic [PIXEL_WIDTH-1:0] out_rd_11
);

    sync_t sync_in;
    sync_t sync_out;
    word_t pixel_word;

    line_buf_if line_buf_bus ();

    // raw timing into one group
    assign sync_in.de    = in_de;
    assign sync_in.valid = in_valid;
    assign sync_in.hsync = in_hs;
    assign sync_in.vsync = in_vs;

    stream_capture stream_capture_inst (
        .out_clk    (out_clk),
        .rstn       (rstn),
        .in_tvalid  (in_tvalid),
        .in_tdata   (in_tdata),
        .in_tkeep   (in_tkeep),
        .in_de      (in_de),
        .in_vs      (in_vs),
        .out_tready (out_tready),
        .lbuf       (line_buf_bus)
    );

    line_buffer line_buffer_inst (
        .out_clk (out_clk),
        .rstn    (rstn),
        .lbuf    (line_buf_bus)
    );

    sync_replay sync_replay_inst (
        .out_clk    (out_clk),
        .rstn       (rstn),
        .sync_in    (sync_in),
        .sync_out   (sync_out),
        .pixel_word (pixel_word),
        .lbuf       (line_buf_bus)
    );

    assign out_de    = sync_out.de;
    assign out_valid = sync_out.valid;
    assign out_hsync = sync_out.hsync;
    assign out_vsync = sync_out.vsync;

    // 00 is the low byte lane
    assign out_rd_00 = pixel_word[PIXEL_WIDTH-1:0];
    assign out_rd_01 = pixel_word[2*PIXEL_WIDTH-1:PIXEL_WIDTH];
    assign out_rd_10 = pixel_word[3*PIXEL_WIDTH-1:2*PIXEL_WIDTH];
    assign out_rd_11 = pixel_word[4*PIXEL_WIDTH-1:3*PIXEL_WIDTH];

endmodule

// ==== testbench/tb_axi_stream_video_out.sv ====
module tb_axi_stream_video_out
    import video_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int MAX_WORDS    = 256;
    // vsync high before the first line and after the last one
    localparam int VS_LEAD      = 2;
    localparam int VS_TAIL      = LINE_PERIOD + 4;
    localparam int HS_LEN       = 2;

    logic        out_clk;
    logic        rstn;
    logic        in_tvalid;
    logic [31:0] in_tdata;
    logic [3:0]  in_tkeep;
    logic        out_tready;
    logic        in_valid;
    logic        in_de;
    logic        in_hs;
    logic        in_vs;
    logic        out_de;
    logic        out_valid;
    logic        out_hsync;
    logic        out_vsync;
    logic [7:0]  out_rd_00;
    logic [7:0]  out_rd_01;
    logic [7:0]  out_rd_10;
    logic [7:0]  out_rd_11;

    // trace contents with one timing entry per clock
    logic [31:0] pix [MAX_WORDS];
    int          stall_len [MAX_WORDS];
    int          npix;
    sync_t       timing [$];
    bit          no_start [$];

    int seed = 93185;
    int mismatches;
    int failures;
    int run_cycles;
    bit loaded;

    axi_stream_video_out axi_stream_video_out_inst (
        .out_clk    (out_clk),
        .rstn       (rstn),
        .in_tvalid  (in_tvalid),
        .in_tdata   (in_tdata),
        .in_tkeep   (in_tkeep),
        .out_tready (out_tready),
        .in_valid   (in_valid),
        .in_de      (in_de),
        .in_hs      (in_hs),
        .in_vs      (in_vs),
        .out_de     (out_de),
        .out_valid  (out_valid),
        .out_hsync  (out_hsync),
        .out_vsync  (out_vsync),
        .out_rd_00  (out_rd_00),
        .out_rd_01  (out_rd_01),
        .out_rd_10  (out_rd_10),
        .out_rd_11  (out_rd_11)
    );

    initial
    begin
        out_clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) out_clk = ~out_clk;
    end

    task automatic add_cycles(input sync_t s, input bit hold, input int n);
        for (int i = 0; i < n; i++)
        begin
            timing.push_back(s);
            no_start.push_back(hold);
        end
    endtask

    // vblank gap, vsync rise, lines, then a tail long enough to drain the delay
    task automatic build_frame(input int lines, input int pixels, input int hblank,
                               input int vblank, input bit start);
        sync_t frame_hi;
        sync_t line_hs;
        sync_t line_de;
        frame_hi       = '0;
        frame_hi.vsync = 1'b1;
        line_hs        = frame_hi;
        line_hs.valid  = 1'b1;
        line_hs.hsync  = 1'b1;
        line_de        = frame_hi;
        line_de.valid  = 1'b1;
        line_de.de     = 1'b1;
        add_cycles('0, 1'b0, vblank);
        // tvalid is held back on the rise cycle of a frame that must not start
        add_cycles(frame_hi, !start, 1);
        add_cycles(frame_hi, 1'b0, VS_LEAD - 1);
        for (int l = 0; l < lines; l++)
        begin
            add_cycles(line_hs, 1'b0, HS_LEN);
            add_cycles(line_de, 1'b0, pixels);
            add_cycles(frame_hi, 1'b0, hblank);
        end
        add_cycles(frame_hi, 1'b0, VS_TAIL);
    endtask

    task automatic read_trace();
        int          fd;
        int          n;
        int          need;
        int          a;
        int          b;
        int          c;
        int          d;
        int          e;
        logic [31:0] w;
        string       line;
        string       fields;
        fd = $fopen("testbench/video_out_trace.txt", "r");
        if (fd == 0)
        begin
            failures++;
            $display("could not open the trace file testbench/video_out_trace.txt");
            return;
        end
        while ($fgets(line, fd) > 0)
        begin
            // blank lines and comments carry nothing
            if (line.len() < 2)
                continue;
            fields = line.substr(1, line.len() - 1);
            case (line.getc(0))
                "F":
                begin
                    need = 5;
                    n    = $sscanf(fields, "%d %d %d %d %d", a, b, c, d, e);
                    build_frame(a, b, c, d, e != 0);
                end
                "S":
                begin
                    need = 2;
                    n    = $sscanf(fields, "%d %d", a, b);
                    stall_len[a] = b;
                end
                "P":
                begin
                    need = 1;
                    n    = $sscanf(fields, "%h", w);
                    pix[npix] = w;
                    npix++;
                end
                default:
                begin
                    need = 0;
                    n    = 0;
                end
            endcase
            if (n != need)
            begin
                failures++;
                $display("trace record is missing fields: %s", line);
            end
        end
        $fclose(fd);
    endtask

    initial
    begin
        int          src_idx;
        int          out_idx;
        int          stall_left;
        int          partial_left;
        int          req;
        int          acc;
        bit          frame_open;
        bit          hold;
        bit          exp_tready;
        logic        prev_tready;
        logic        prev_tvalid;
        logic [3:0]  prev_keep;
        logic [31:0] got;
        sync_t       cur;
        sync_t       prev;
        sync_t       prev2;
        sync_t       got_sync;
        sync_t       exp_sync;
        sync_t       hist [$];
        src_idx      = 0;
        out_idx      = 0;
        stall_left   = 0;
        partial_left = 0;
        req          = 0;
        acc          = 0;
        frame_open   = 1'b0;
        prev_tready  = 1'b0;
        prev_tvalid  = 1'b0;
        prev_keep    = '0;
        prev         = '0;
        prev2        = '0;
        rstn         = 1'b0;
        in_tvalid    = 1'b0;
        in_tdata     = '0;
        in_tkeep     = '0;
        in_valid     = 1'b0;
        in_de        = 1'b0;
        in_hs        = 1'b0;
        in_vs        = 1'b0;
        read_trace();
        // trailing idle cycles let the last delayed pixels come out
        run_cycles = timing.size() + LINE_PERIOD + 4;
        loaded     = 1'b1;
        repeat (RESET_CYCLES) @(negedge out_clk);
        rstn = 1'b1;
        for (int cyc = 0; cyc < run_cycles; cyc++)
        begin
            // replay what the DUT saw on the last rising edge
            if (prev.vsync && !prev2.vsync && prev_tvalid && !frame_open)
            begin
                frame_open   = 1'b1;
                req          = 0;
                acc          = 0;
                partial_left = 2;
            end
            else if (!prev.vsync && prev2.vsync)
                frame_open = 1'b0;
            if (frame_open && prev.de)
                req++;
            if (prev_tready && prev_tvalid && prev_keep == 4'hf)
            begin
                acc++;
                stall_left = stall_len[src_idx];
                src_idx++;
            end
            // ready only while requests are still open in a started frame
            exp_tready = frame_open && (req != acc);
            assert (out_tready === exp_tready)
            else
            begin
                mismatches++;
                $display("MISMATCH %0t: out_tready %b, expected %b (%0d requests, %0d accepted)",
                         $time, out_tready, exp_tready, req, acc);
            end
            exp_sync = (hist.size() == LINE_PERIOD + 1) ? hist[0] : sync_t'('0);
            got_sync = {out_de, out_valid, out_hsync, out_vsync};
            assert (got_sync === exp_sync)
            else
            begin
                mismatches++;
                $display("MISMATCH %0t: sync de/valid/hs/vs %b, expected %b",
                         $time, got_sync, exp_sync);
            end
            if (out_de === 1'b1)
            begin
                got = {out_rd_11, out_rd_10, out_rd_01, out_rd_00};
                assert (out_idx < npix && got === pix[out_idx])
                else
                begin
                    mismatches++;
                    $display("MISMATCH %0t: pixel %0d is %h, expected %h",
                             $time, out_idx, got, pix[out_idx]);
                end
                out_idx++;
            end
            // video timing for this cycle
            cur  = (cyc < timing.size()) ? timing[cyc] : sync_t'('0);
            hold = (cyc < timing.size()) ? no_start[cyc] : 1'b0;
            in_de    = cur.de;
            in_valid = cur.valid;
            in_hs    = cur.hsync;
            in_vs    = cur.vsync;
            // stream source
            in_tvalid = (src_idx < npix) && (stall_left == 0) && !hold;
            in_tdata  = (src_idx < npix) ? pix[src_idx] : '0;
            in_tkeep  = 4'hf;
            if (in_tvalid && out_tready && partial_left > 0 && ($random(seed) & 3) == 0)
            begin
                // drop one lane so the DUT lets this beat pass
                in_tkeep = 4'b1111 ^ (4'b0001 << ($random(seed) & 3));
                partial_left--;
            end
            if (stall_left > 0)
                stall_left--;
            prev2       = prev;
            prev        = cur;
            prev_tvalid = in_tvalid;
            prev_keep   = in_tkeep;
            prev_tready = out_tready;
            hist.push_back(cur);
            if (hist.size() > LINE_PERIOD + 1)
                hist.pop_front();
            @(negedge out_clk);
        end
        assert (out_idx == npix && src_idx == npix)
        else
        begin
            mismatches++;
            $display("MISMATCH %0t: %0d words accepted and %0d shown, expected %0d",
                     $time, src_idx, out_idx, npix);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // twice the traced run plus one line period
    initial
    begin
        wait (loaded);
        repeat (2 * run_cycles + LINE_PERIOD) @(posedge out_clk);
        $display("watchdog timeout, the run did not end after %0d cycles",
                 2 * run_cycles + LINE_PERIOD);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== testbench/video_out_trace.txt ====
# F lines pixels hblank vblank start (start 0 holds tvalid low at the vsync rise)
# S word cycles (tvalid low for that many cycles after the 0 based word is accepted)
# P word (expected output word in order, also fed on the stream)
F 2 4 5 6 1
F 0 0 0 6 0
F 2 5 4 6 1
S 2 3
S 12 2
P a1b2c3d4
P 0f1e2d3c
P 55aa33cc
P 12345678
P 89abcdef
P 7e6d5c4b
P c0ffee01
P 3a5b7c9d
P 10203040
P f0e1d2c3
P 6b8a4c2e
P 99887766
P 01234567
P fedcba98
P 2468ace0
P 13579bdf
P 5a5aa5a5
P 0badf00d

// ==== compile.f ====
hw/stream_pkg.sv
hw/video_pkg.sv
hw/line_buf_if.sv
hw/stream_capture.sv
hw/line_buffer.sv
hw/sync_replay.sv
hw/axi_stream_video_out.sv
testbench/tb_axi_stream_video_out.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_axi_stream_video_out -f compile.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Simulation passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
